//--- bench/mul_unit_tb.sv
`timescale 1ns/1ps

`include "mul_params.svh"

module mul_unit_tb;

    localparam int CLK_PERIOD  = 100;
    localparam int N_CORNER    = 14;
    localparam int N_RAND      = 40;
    localparam int N_ROWS      = N_CORNER + N_RAND;
    // worst row is 34 cycles of latency plus a gap of 2 and handshake slack
    localparam int ROW_CYCLES  = 40;
    localparam int MAX_LATENCY = 34;
    // one spare row for reset
    localparam int WATCHDOG_NS = (N_ROWS + 1) * ROW_CYCLES * CLK_PERIOD;

    logic                 clk;
    logic                 rst;
    logic                 req_valid;
    logic [`MUL_OPW-1:0]  req_op;
    logic [`MUL_XLEN-1:0] req_a;
    logic [`MUL_XLEN-1:0] req_b;
    logic                 req_ready;
    logic                 resp_valid;
    logic [`MUL_XLEN-1:0] resp_data;

    ////////////////////////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////////////////////////

    logic [`MUL_OPW-1:0]  tbl_op  [N_ROWS];
    logic [`MUL_XLEN-1:0] tbl_a   [N_ROWS];
    logic [`MUL_XLEN-1:0] tbl_b   [N_ROWS];
    // expected response word
    logic [`MUL_XLEN-1:0] tbl_exp [N_ROWS];
    // idle cycles before the next request
    // zero keeps the next request valid while busy
    int                   tbl_gap [N_ROWS];

    integer seed;
    int     accept_count;
    int     resp_count;

    mul_unit u_mul_unit (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_op     (req_op),
        .req_a      (req_a),
        .req_b      (req_b),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_data  (resp_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // handshakes the DUT really performed
    always @(posedge clk) begin
        if (!rst) begin
            if (req_valid && req_ready) begin
                accept_count++;
            end
            if (resp_valid) begin
                resp_count++;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // reference model and checks
    ////////////////////////////////////////////////////////////

    // full product of the widened operands, then the word the op asks for
    function automatic logic [`MUL_XLEN-1:0] model_result(input logic [`MUL_OPW-1:0] op,
                                                         input logic [`MUL_XLEN-1:0] a,
                                                         input logic [`MUL_XLEN-1:0] b);
        logic                   a_signed;
        logic                   b_signed;
        logic [`MUL_PWIDTH-1:0] a_wide;
        logic [`MUL_PWIDTH-1:0] b_wide;
        logic [`MUL_PWIDTH-1:0] prod;
        a_signed = (op != `MUL_OP_MULHU);
        b_signed = (op != `MUL_OP_MULHU) && (op != `MUL_OP_MULHSU);
        a_wide = {{`MUL_XLEN{a_signed & a[`MUL_XLEN-1]}}, a};
        b_wide = {{`MUL_XLEN{b_signed & b[`MUL_XLEN-1]}}, b};
        prod = a_wide * b_wide;
        case (op)
            `MUL_OP_MUL:  model_result = prod[`MUL_XLEN-1:0];
            `MUL_OP_MULW: model_result = {{32{prod[31]}}, prod[31:0]};
            default:      model_result = prod[`MUL_PWIDTH-1:`MUL_XLEN];
        endcase
    endfunction

    task automatic stop_on_failure();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_data(input string name, input int row,
                              input logic [`MUL_XLEN-1:0] got,
                              input logic [`MUL_XLEN-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %s row %0d got %h expected %h", name, row, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(input string name, input int row,
                              input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s row %0d got %h expected %h", name, row, got, exp);
            stop_on_failure();
        end
    endtask

    // one accept and one response per row
    task automatic check_counts(input int row, input int accepts, input int resps);
        if (accept_count != accepts || resp_count != resps) begin
            $display("row %0d saw %0d accepts and %0d responses where %0d and %0d were due",
                     row, accept_count, resp_count, accepts, resps);
            stop_on_failure();
        end
    endtask

    task automatic set_row(input int idx, input logic [`MUL_OPW-1:0] op,
                           input logic [`MUL_XLEN-1:0] a, input logic [`MUL_XLEN-1:0] b,
                           input int gap);
        tbl_op[idx]  = op;
        tbl_a[idx]   = a;
        tbl_b[idx]   = b;
        tbl_gap[idx] = gap;
        tbl_exp[idx] = model_result(op, a, b);
    endtask

    task automatic drive_request(input int idx);
        req_valid = 1'b1;
        req_op    = tbl_op[idx];
        req_a     = tbl_a[idx];
        req_b     = tbl_b[idx];
    endtask

    ////////////////////////////////////////////////////////////
    // watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, no response arrived in time");
        stop_on_failure();
    end

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int r;
        int latency;
        logic [`MUL_OPW-1:0]  op;
        logic [`MUL_XLEN-1:0] a;
        logic [`MUL_XLEN-1:0] b;

        rst          = 1'b1;
        req_valid    = 1'b0;
        req_op       = '0;
        req_a        = '0;
        req_b        = '0;
        seed         = 32'h92e6488d;
        accept_count = 0;
        resp_count   = 0;

        // corner rows first
        // a feeds the multiplier so a small a ends early
        set_row(0,  `MUL_OP_MUL,    64'h0, 64'h0, 1);
        set_row(1,  `MUL_OP_MUL,    64'h1, 64'h1, 0);
        set_row(2,  `MUL_OP_MUL,    '1, '1, 0);
        set_row(3,  `MUL_OP_MULHU,  '1, '1, 2);
        set_row(4,  `MUL_OP_MULH,   64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000, 0);
        set_row(5,  `MUL_OP_MULH,   64'h8000_0000_0000_0000, '1, 1);
        set_row(6,  `MUL_OP_MUL,    64'h8000_0000_0000_0000, '1, 0);
        set_row(7,  `MUL_OP_MULHSU, '1, '1, 0);
        set_row(8,  `MUL_OP_MULHSU, 64'h5, 64'hffff_ffff_0000_0001, 1);
        set_row(9,  `MUL_OP_MULHSU, 64'h8000_0000_0000_0000, 64'h2, 0);
        set_row(10, `MUL_OP_MULW,   64'h3, 64'h7, 0);
        set_row(11, `MUL_OP_MULW,   64'h7fff_ffff, 64'h2, 2);
        set_row(12, `MUL_OP_MUL,    64'h2, 64'h1234_5678_9abc_def0, 0);
        set_row(13, `MUL_OP_MULHU,  64'h1, '1, 1);

        for (int i = N_CORNER; i < N_ROWS; i++) begin
            r  = $random(seed);
            op = r[7:0] % 8'd5;
            a  = {$random(seed), $random(seed)};
            b  = {$random(seed), $random(seed)};
            // short multiplier on every fourth row
            if (i % 4 == 0) begin
                a = a & 64'h3ff;
            end
            set_row(i, op, a, b, r[15:8] % 8'd3);
        end

        // 3 rising edges in reset
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_flag("resp_valid", -1, resp_valid, 1'b0);
        check_flag("req_ready", -1, req_ready, 1'b1);

        for (int i = 0; i < N_ROWS; i++) begin
            drive_request(i);
            while (req_ready !== 1'b1) begin
                check_flag("resp_valid", i, resp_valid, 1'b0);
                check_counts(i, i, i);
                @(negedge clk);
            end
            // accepted on the next rising edge
            @(negedge clk);
            if (tbl_gap[i] == 0 && i + 1 < N_ROWS) begin
                // next request waits on the bus while busy
                drive_request(i + 1);
            end else begin
                req_valid = 1'b0;
            end

            latency = 0;
            while (resp_valid !== 1'b1) begin
                check_flag("req_ready", i, req_ready, 1'b0);
                check_counts(i, i + 1, i);
                latency++;
                if (latency > MAX_LATENCY) begin
                    $display("no response within %0d cycles for row %0d", MAX_LATENCY, i);
                    stop_on_failure();
                end
                @(negedge clk);
            end
            check_data("resp_data", i, resp_data, tbl_exp[i]);
            check_flag("req_ready", i, req_ready, 1'b0);

            // one cycle pulse then ready again
            @(negedge clk);
            check_flag("resp_valid", i, resp_valid, 1'b0);
            check_flag("req_ready", i, req_ready, 1'b1);
            check_counts(i, i + 1, i + 1);
            repeat (tbl_gap[i]) begin
                @(negedge clk);
                check_flag("resp_valid", i, resp_valid, 1'b0);
            end
        end

        req_valid = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_flag("resp_valid", N_ROWS, resp_valid, 1'b0);
        end

        if (accept_count == N_ROWS && resp_count == N_ROWS) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("%0d requests accepted and %0d responses seen, expected %0d of each",
                     accept_count, resp_count, N_ROWS);
            stop_on_failure();
        end
    end

endmodule

//--- src/booth_mul_serial.sv
`timescale 1ns/1ps

`include "mul_params.svh"

module booth_mul_serial (
    input  logic                     clk,
    input  logic                     rst,
    // one cycle load pulse
    input  logic                     start,
    // multiplier, consumed two bits per cycle
    input  logic [`MUL_XLEN-1:0]     mul1,
    // multiplicand
    input  logic [`MUL_XLEN-1:0]     mul2,
    // treat mul1 as signed
    input  logic                     sign1,
    // treat mul2 as signed
    input  logic                     sign2,
    // one cycle strobe, product valid with it
    output logic                     done,
    output mul_pkg::mul_product_u    product
);

    // 2 sign bits + operand + appended zero
    localparam int MPLR_W  = `MUL_XLEN + 3;
    // product width plus headroom for the x2 digit and sign
    localparam int MCAND_W = `MUL_PWIDTH + 4;

    ////////////////////////////////////////////////////////////
    // operand load
    ////////////////////////////////////////////////////////////

    // sign extension bits, zero for unsigned operands
    logic ext1;
    logic ext2;

    assign ext1 = sign1 & mul1[`MUL_XLEN-1];
    assign ext2 = sign2 & mul2[`MUL_XLEN-1];

    // multiplier shift register, right by two
    logic [MPLR_W-1:0]  mplr_q;
    // multiplicand shift register, left by two
    logic [MCAND_W-1:0] mcand_q;
    // running partial sum
    logic [MCAND_W-1:0] acc_q;

    // iteration count and busy flag
    logic [5:0] iter_q;
    logic       running_q;

    // decoder interface
    logic [2:0]         booth;
    logic [MCAND_W-1:0] partial_sum;
    logic               partial_c;
    logic [MCAND_W-1:0] acc_d;

    // datapath registers hold while idle
    always_ff @(posedge clk) begin
        if (start) begin
            mplr_q  <= {{2{ext1}}, mul1, 1'b0};
            mcand_q <= {{(MCAND_W-`MUL_XLEN){ext2}}, mul2};
            acc_q   <= '0;
        end else if (running_q) begin
            mplr_q  <= {2'b00, mplr_q[MPLR_W-1:2]};
            mcand_q <= {mcand_q[MCAND_W-3:0], 2'b00};
            acc_q   <= acc_d;
        end
    end

    ////////////////////////////////////////////////////////////
    // partial product and accumulate
    ////////////////////////////////////////////////////////////

    // lowest triplet is the current digit
    assign booth = mplr_q[2:0];

    radix4_unit u_radix4 (
        .booth        (booth),
        .multiplicand (mcand_q),
        .partial_sum  (partial_sum),
        .partial_c    (partial_c)
    );

    // single adder, carry finishes the negation
    assign acc_d = partial_sum + acc_q + {{(MCAND_W-1){1'b0}}, partial_c};

    // product comes straight off the adder, so it holds the last digit
    assign product.raw = acc_d[`MUL_PWIDTH-1:0];

    ////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            running_q <= 1'b0;
        end else if (start) begin
            running_q <= 1'b1;
        end else if (done) begin
            running_q <= 1'b0;
        end
    end

    // counts digits already added
    always_ff @(posedge clk) begin
        if (rst) begin
            iter_q <= '0;
        end else if (start || done) begin
            iter_q <= '0;
        end else if (running_q) begin
            iter_q <= iter_q + 6'd1;
        end
    end

    // finish on the 33rd digit
    // or early once nothing is left above bit 0
    // the last digit {0,0,b} is still added this cycle
    assign done = running_q & (iter_q[5] | ~|mplr_q[MPLR_W-1:1]);

endmodule

//--- src/mul_ctrl.sv
`timescale 1ns/1ps

`include "mul_params.svh"

module mul_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    // request from the core
    input  logic                     req_valid,
    input  logic [`MUL_OPW-1:0]      req_op,
    input  logic [`MUL_XLEN-1:0]     req_a,
    input  logic [`MUL_XLEN-1:0]     req_b,
    output logic                     req_ready,
    // to the booth multiplier
    output logic                     start,
    output logic [`MUL_XLEN-1:0]     mul1,
    output logic [`MUL_XLEN-1:0]     mul2,
    output logic                     sign1,
    output logic                     sign2,
    // from the booth multiplier
    input  logic                     done,
    input  mul_pkg::mul_product_u    product,
    // response, no back-pressure
    output logic                     resp_valid,
    output logic [`MUL_XLEN-1:0]     resp_data
);

    localparam int HALF = `MUL_XLEN / 2;

    // one request in flight
    logic                busy_q;
    // operation held for result shaping
    logic [`MUL_OPW-1:0] op_q;
    // MULW result, low half sign extended
    logic [`MUL_XLEN-1:0] word_sext;

    ////////////////////////////////////////////////////////////
    // request side
    ////////////////////////////////////////////////////////////

    // ready drops on accept, comes back the cycle after the response
    assign req_ready = ~busy_q;

    // accept and launch in the same edge
    assign start = req_valid & req_ready;

    // the multiplier loads the operands on the accept edge
    assign mul1 = req_a;
    assign mul2 = req_b;

    // signedness per operation
    // low word ops do not care, run them signed
    always_comb begin
        case (req_op)
            `MUL_OP_MULHSU: begin
                sign1 = 1'b1;
                sign2 = 1'b0;
            end
            `MUL_OP_MULHU: begin
                sign1 = 1'b0;
                sign2 = 1'b0;
            end
            // MUL, MULH, MULW
            default: begin
                sign1 = 1'b1;
                sign2 = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (start) begin
            op_q <= req_op;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
        end else if (start) begin
            busy_q <= 1'b1;
        end else if (resp_valid) begin
            busy_q <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // response side
    ////////////////////////////////////////////////////////////

    assign word_sext = {{HALF{product.half.lo[HALF-1]}}, product.half.lo[HALF-1:0]};

    // response one cycle after done
    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= done;
        end
    end

    // product only valid with done, capture it then
    always_ff @(posedge clk) begin
        if (done) begin
            case (op_q)
                `MUL_OP_MULH,
                `MUL_OP_MULHSU,
                `MUL_OP_MULHU: begin
                    resp_data <= product.half.hi;
                end
                `MUL_OP_MULW: begin
                    resp_data <= word_sext;
                end
                // plain MUL
                default: begin
                    resp_data <= product.half.lo;
                end
            endcase
        end
    end

endmodule

//--- src/mul_params.svh
`ifndef MUL_PARAMS_SVH
`define MUL_PARAMS_SVH

////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////

// one operand word
`define MUL_XLEN 64
// full product of two operand words
`define MUL_PWIDTH (2 * `MUL_XLEN)

////////////////////////////////////////////////////////////
// operation codes
////////////////////////////////////////////////////////////

`define MUL_OPW 3

// low word of the product
`define MUL_OP_MUL    3'd0
// high word, signed x signed
`define MUL_OP_MULH   3'd1
// high word, signed x unsigned
`define MUL_OP_MULHSU 3'd2
// high word, unsigned x unsigned
`define MUL_OP_MULHU  3'd3
// low 32 bits, sign extended to a full word
`define MUL_OP_MULW   3'd4

`endif

//--- src/mul_pkg.sv
`include "mul_params.svh"

package mul_pkg;

    ////////////////////////////////////////////////////////////
    // product word
    ////////////////////////////////////////////////////////////

    // the multiplier produces one flat product word
    // the control block only ever wants one half of it
    // both views share the same 128 bits
    //
    // layout
    //   raw       full two's complement product
    //   half.hi   upper operand-width word
    //   half.lo   lower operand-width word
    typedef union packed {
        // flat view, written by the booth datapath
        logic [`MUL_PWIDTH-1:0] raw;
        // split view, read by result selection
        struct packed {
            // upper word, MULH / MULHSU / MULHU
            logic [`MUL_XLEN-1:0] hi;
            // lower word, MUL and MULW
            logic [`MUL_XLEN-1:0] lo;
        } half;
    } mul_product_u;

    // hi sits in the upper bits of raw since the struct is packed
    // msb first, so half.hi == raw[127:64]
    // and half.lo == raw[63:0]

endpackage

//--- src/mul_unit.sv
`timescale 1ns/1ps

`include "mul_params.svh"

module mul_unit (
    input  logic                     clk,
    input  logic                     rst,
    // request
    input  logic                     req_valid,
    input  logic [`MUL_OPW-1:0]      req_op,
    input  logic [`MUL_XLEN-1:0]     req_a,
    input  logic [`MUL_XLEN-1:0]     req_b,
    output logic                     req_ready,
    // response
    output logic                     resp_valid,
    output logic [`MUL_XLEN-1:0]     resp_data
);

    ////////////////////////////////////////////////////////////
    // control <-> multiplier
    ////////////////////////////////////////////////////////////

    // launch
    logic                  start;
    logic [`MUL_XLEN-1:0]  mul1;
    logic [`MUL_XLEN-1:0]  mul2;
    logic                  sign1;
    logic                  sign2;

    // completion
    logic                  done;
    mul_pkg::mul_product_u product;

    // request handling and result shaping
    mul_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_op     (req_op),
        .req_a      (req_a),
        .req_b      (req_b),
        .req_ready  (req_ready),
        .start      (start),
        .mul1       (mul1),
        .mul2       (mul2),
        .sign1      (sign1),
        .sign2      (sign2),
        .done       (done),
        .product    (product),
        .resp_valid (resp_valid),
        .resp_data  (resp_data)
    );

    // serial radix-4 datapath
    booth_mul_serial u_booth (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .mul1    (mul1),
        .mul2    (mul2),
        .sign1   (sign1),
        .sign2   (sign2),
        .done    (done),
        .product (product)
    );

endmodule

//--- src/radix4_unit.sv
`timescale 1ns/1ps

`include "mul_params.svh"

module radix4_unit (
    // booth triplet {b[2i+1], b[2i], b[2i-1]}
    input  logic [2:0]                 booth,
    // sign extended, already shifted multiplicand
    input  logic [`MUL_PWIDTH+3:0]     multiplicand,
    // partial product, inverted when negative
    output logic [`MUL_PWIDTH+3:0]     partial_sum,
    // +1 completing the two's complement of a negative partial
    output logic                       partial_c
);

    ////////////////////////////////////////////////////////////
    // digit decode
    ////////////////////////////////////////////////////////////

    // digit selects
    logic sel_one;
    logic sel_two;
    logic sel_neg;

    // magnitude before any inversion
    logic [`MUL_PWIDTH+3:0] magnitude;

    always_comb begin
        sel_one = 1'b0;
        sel_two = 1'b0;
        sel_neg = 1'b0;
        case (booth)
            // +1
            3'b001, 3'b010: begin
                sel_one = 1'b1;
            end
            // +2
            3'b011: begin
                sel_two = 1'b1;
            end
            // -2
            3'b100: begin
                sel_two = 1'b1;
                sel_neg = 1'b1;
            end
            // -1
            3'b101, 3'b110: begin
                sel_one = 1'b1;
                sel_neg = 1'b1;
            end
            // 000 and 111 both mean zero, no carry
            default: begin
                sel_one = 1'b0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // partial product
    ////////////////////////////////////////////////////////////

    // x2 is a left shift, top bit is only sign extension
    always_comb begin
        if (sel_two) begin
            magnitude = {multiplicand[`MUL_PWIDTH+2:0], 1'b0};
        end else if (sel_one) begin
            magnitude = multiplicand;
        end else begin
            magnitude = '0;
        end
    end

    // negative digit -> ones complement here, +1 in the accumulator adder
    assign partial_sum = sel_neg ? ~magnitude : magnitude;
    assign partial_c   = sel_neg;

endmodule

//--- vlog.f
+incdir+src
src/mul_pkg.sv
src/radix4_unit.sv
src/booth_mul_serial.sv
src/mul_ctrl.sv
src/mul_unit.sv
bench/mul_unit_tb.sv
